// File: Makefile
TOP = ir_decoder_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f ir_decoder.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f ir_decoder.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: include/ir_decoder_params.svh
`ifndef IR_DECODER_PARAMS_SVH
`define IR_DECODER_PARAMS_SVH

// address halves of the eight known remotes
`define REMOTE_ADDR_0 16'h807F
`define REMOTE_ADDR_1 16'h40BF
`define REMOTE_ADDR_2 16'hC03F
`define REMOTE_ADDR_3 16'h20DF
`define REMOTE_ADDR_4 16'hA05F
`define REMOTE_ADDR_5 16'h609F
`define REMOTE_ADDR_6 16'hE01F
`define REMOTE_ADDR_7 16'h10EF

// key bytes shared by all remotes, command n is KEY_BYTE_n
`define KEY_BYTE_0  8'h12
`define KEY_BYTE_1  8'h01
`define KEY_BYTE_2  8'h02
`define KEY_BYTE_3  8'h03
`define KEY_BYTE_4  8'h04
`define KEY_BYTE_5  8'h05
`define KEY_BYTE_6  8'h06
`define KEY_BYTE_7  8'h07
`define KEY_BYTE_8  8'h08
`define KEY_BYTE_9  8'h09
`define KEY_BYTE_10 8'h0A
`define KEY_BYTE_11 8'h1E
`define KEY_BYTE_12 8'h1F
`define KEY_BYTE_13 8'h1A
`define KEY_BYTE_14 8'h10
`define KEY_BYTE_15 8'h0C

// settle window in data-ready cycles
`define WINDOW_BEGIN 48
`define WINDOW_END   58

// bus address of the result register
`define DECODER_ADDR 32'hFFFF_1410

// result word with nothing captured
`define INVALID_WORD 32'h8000_0000

`endif

// File: ir_decoder.f
+incdir+include
src/ir_code_pkg.sv
src/bus_pkg.sv
src/capture_if.sv
src/ir_code_decode.sv
src/ready_window.sv
src/code_register.sv
src/ir_decoder.sv
sim/ir_decoder_assert.sv
sim/ir_decoder_tb.sv

// File: sim/ir_decoder_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_decoder_params.svh"

module ir_decoder_assert import ir_code_pkg::*, bus_pkg::*; (
	input logic      iCLK,
	input logic      rst_n,
	input logic      read_en,
	input bus_addr_t read_addr,
	input bus_word_t read_data,
	input logic      req,
	input logic      ack
);

	logic          addr_hit;
	logic          cleared;     // addressed read seen, no capture since
	remote_field_u read_field;  // low half of the word on the bus

	assign addr_hit   = read_en && (read_addr == `DECODER_ADDR);
	assign read_field = read_data[15:0];

	always_ff @(posedge iCLK or negedge rst_n)
	begin
		if (!rst_n)
			cleared <= 1'b0;
		else if (addr_hit)
			cleared <= 1'b1;  // read wins over a capture on the same edge
		else if (req && !ack)
			cleared <= 1'b0;
	end

	ack_rise_in_req: assert property (@(posedge iCLK) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	ack_fall_after_req: assert property (@(posedge iCLK) disable iff (!rst_n)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

	read_clears_word: assert property (@(posedge iCLK) disable iff (!rst_n)
		(addr_hit && cleared) |-> (read_data == `INVALID_WORD))
		else $error("second read without capture did not return the invalid word");

	// nothing above the widest remote layout
	field_upper_zero: assert property (@(posedge iCLK) disable iff (!rst_n)
		addr_hit |-> (read_field.word_f.zero == '0))
		else $error("bits above the remote field are set");

endmodule

bind code_register ir_decoder_assert i_ir_decoder_assert (
	.iCLK      (iCLK),
	.rst_n     (rst_n),
	.read_en   (read_en),
	.read_addr (read_addr),
	.read_data (read_data),
	.req       (cap.req),
	.ack       (cap.ack)
);

`default_nettype wire

// File: sim/ir_decoder_stim.txt
# code_word  sel  ready_cycles  expected_read_word  (code and word in hex, cycles decimal)
# sel: 0 byte, 1 halfword, 2 word, 3 acts as byte
ED12807F 0 60 00000000
FE0140BF 1 60 00040002
FD02C03F 2 60 00080008
FC0320DF 3 60 000C0003
FB04A05F 0 90 00100004
FA05609F 1 60 0014000A
F906E01F 2 60 00180018
F80710EF 0 60 001C0007
F70810EF 1 60 0020000E
F609E01F 3 60 00240006
F50A609F 2 60 00280014
E11EA05F 1 60 002C0008
E01F20DF 2 60 0030000C
E51AC03F 0 60 00340002
EF1040BF 3 60 00380001
F30C20DF 2 60 003C000C
F30C10EF 3 60 003C0007
0012C03F 0 60 80000002
CC33A05F 1 60 80000008
FA051234 2 60 80000000
FE0140BF 0 30 80000000
FB04A05F 2 47 80000000

// File: sim/ir_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_decoder_params.svh"

module ir_decoder_tb import ir_code_pkg::*, bus_pkg::*; ();

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 5;    // after the rising edge
	localparam int RESET_CYCLES    = 10;
	localparam int SETTLE_CYCLES   = 60;   // capture lands around cycle 50
	localparam int CYCLES_PER_TEST = 100;
	localparam int SEED            = 16027;
	localparam bus_addr_t OTHER_ADDR = 32'hFFFF_1414;

	logic        iCLK;
	logic        rst_n;
	ir_code_t    ir_code;
	logic        ir_ready;
	access_sel_t sel;
	logic        read_en;
	bus_addr_t   read_addr;
	bus_word_t   read_data;

	// one entry per stim line
	bus_word_t  code_q[$];
	logic [1:0] sel_q[$];
	int         ready_q[$];
	bus_word_t  expect_q[$];

	ir_decoder i_ir_decoder (
		.iCLK      (iCLK),
		.rst_n     (rst_n),
		.ir_code   (ir_code),
		.ir_ready  (ir_ready),
		.sel       (sel),
		.read_en   (read_en),
		.read_addr (read_addr),
		.read_data (read_data)
	);

	always #(CLK_PERIOD / 2) iCLK = ~iCLK;

	task automatic check_value(input bus_word_t got, input bus_word_t expected, input string what);
		if (got !== expected)
		begin
			$display("FAILED at %0d ns: %s, got %08h, expected %08h", $time, what, got, expected);
			$display("Done: errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_stimulus();
		int        fd;
		int        n;
		int        sel_v;
		int        cycles;
		string     line;
		bus_word_t code_w;
		bus_word_t exp_w;
		fd = $fopen("sim/ir_decoder_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file sim/ir_decoder_stim.txt");
			$display("Done: errors found");
			$fatal(1, "no stimulus file");
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				n = $sscanf(line, "%h %h %d %h", code_w, sel_v, cycles, exp_w);
				if (n == 4)  // comment and blank lines fall through
				begin
					code_q.push_back(code_w);
					sel_q.push_back(sel_v[1:0]);
					ready_q.push_back(cycles);
					expect_q.push_back(exp_w);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic next_cycle();
		@(posedge iCLK);
		#DRIVE_DELAY;
	endtask

	// one-cycle read strobe, data sampled mid-cycle
	task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
		read_en   = 1'b1;
		read_addr = addr;
		@(negedge iCLK);
		data = read_data;
		next_cycle();
		read_en   = 1'b0;
		read_addr = '0;
	endtask

	task automatic watchdog(input int n_tests);
		#((n_tests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles",
		         n_tests * CYCLES_PER_TEST + RESET_CYCLES);
		$display("Done: errors found");
		$fatal(1, "timeout");
	endtask

	task automatic run_test(input int idx);
		bus_word_t data;
		int        gap;
		gap = $urandom_range(8, 1);
		repeat (gap) next_cycle();
		ir_code  = code_q[idx];
		sel      = access_sel_t'(sel_q[idx]);
		ir_ready = 1'b1;
		repeat (ready_q[idx]) next_cycle();
		ir_ready = 1'b0;
		if (ready_q[idx] < SETTLE_CYCLES)
			repeat (SETTLE_CYCLES - ready_q[idx]) next_cycle();
		repeat (2) next_cycle();  // let ack return low

		// another address reads zero and leaves the register alone
		bus_read(OTHER_ADDR, data);
		check_value(data, '0, $sformatf("test %0d read of another address", idx));
		bus_read(`DECODER_ADDR, data);
		check_value(data, expect_q[idx], $sformatf("test %0d captured word", idx));
		bus_read(`DECODER_ADDR, data);
		check_value(data, `INVALID_WORD, $sformatf("test %0d read after clear", idx));
	endtask

	initial
	begin
		bus_word_t data;
		iCLK      = 1'b0;
		rst_n     = 1'b0;
		ir_code   = '0;
		ir_ready  = 1'b0;
		sel       = SEL_BYTE;
		read_en   = 1'b0;
		read_addr = '0;
		void'($urandom(SEED));
		load_stimulus();
		fork
			watchdog(code_q.size());
		join_none

		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;
		next_cycle();
		bus_read(`DECODER_ADDR, data);  // nothing captured yet
		check_value(data, `INVALID_WORD, "read after reset");

		for (int i = 0; i < code_q.size(); i++)
			run_test(i);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data word on the processor bus
	typedef logic [31:0] bus_word_t;

	// byte address on the processor bus
	typedef logic [31:0] bus_addr_t;

	// access width of the load that reads the decoder
	// code 2'd3 has no name and is handled like a byte access
	typedef enum logic [1:0] {
		SEL_BYTE = 2'd0,
		SEL_HALF = 2'd1,
		SEL_WORD = 2'd2
	} access_sel_t;

endpackage

`default_nettype wire

// File: src/capture_if.sv
`timescale 1ns/1ps
`default_nettype none

interface capture_if import ir_code_pkg::*; ();

	logic         invalid;  // code not in the tables
	command_idx_t command;
	remote_idx_t  remote;
	logic         req;      // window open, latch the fields
	logic         ack;      // fields latched

	modport decode_mp (output invalid, output command, output remote);

	modport window_mp (output req, input ack);

	modport register_mp (
		input  invalid,
		input  command,
		input  remote,
		input  req,
		output ack
	);

endinterface

`default_nettype wire

// File: src/code_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_decoder_params.svh"

module code_register import ir_code_pkg::*, bus_pkg::*; (
	input  logic           iCLK,
	input  logic           rst_n,
	input  access_sel_t    sel,
	input  logic           read_en,
	input  bus_addr_t      read_addr,
	output bus_word_t      read_data,
	capture_if.register_mp cap
);

	remote_field_u remote_field;
	bus_word_t     result_word;
	bus_word_t     code_q;     // word returned to the processor
	logic          ack_q;
	logic          addr_hit;

	// remote index aligned to the load width
	always_comb
	begin
		remote_field = '0;
		case (sel)
			SEL_HALF: remote_field.half_f.remote = cap.remote;
			SEL_WORD: remote_field.word_f.remote = cap.remote;
			default:  remote_field.byte_f.remote = cap.remote;  // byte and code 3
		endcase
	end

	assign result_word = {cap.invalid, 9'b0, cap.command, 2'b0, remote_field};

	assign addr_hit = read_en && (read_addr == `DECODER_ADDR);

	always_ff @(posedge iCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			code_q <= `INVALID_WORD;
			ack_q  <= 1'b0;
		end
		else
		begin
			ack_q <= cap.req;  // follows req one edge later, both ways
			if (addr_hit)
				code_q <= `INVALID_WORD;  // read clears, capture on this edge is lost
			else if (cap.req && !ack_q)
				code_q <= result_word;
		end
	end

	assign cap.ack = ack_q;

	assign read_data = addr_hit ? code_q : '0;

endmodule

`default_nettype wire

// File: src/ir_code_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_decoder_params.svh"

module ir_code_decode import ir_code_pkg::*; (
	input  ir_code_t       ir_code,
	capture_if.decode_mp   cap
);

	localparam logic [15:0] REMOTE_TABLE [8] = '{
		`REMOTE_ADDR_0, `REMOTE_ADDR_1, `REMOTE_ADDR_2, `REMOTE_ADDR_3,
		`REMOTE_ADDR_4, `REMOTE_ADDR_5, `REMOTE_ADDR_6, `REMOTE_ADDR_7
	};

	localparam logic [7:0] KEY_TABLE [16] = '{
		`KEY_BYTE_0,  `KEY_BYTE_1,  `KEY_BYTE_2,  `KEY_BYTE_3,
		`KEY_BYTE_4,  `KEY_BYTE_5,  `KEY_BYTE_6,  `KEY_BYTE_7,
		`KEY_BYTE_8,  `KEY_BYTE_9,  `KEY_BYTE_10, `KEY_BYTE_11,
		`KEY_BYTE_12, `KEY_BYTE_13, `KEY_BYTE_14, `KEY_BYTE_15
	};

	logic         remote_hit;
	logic         key_hit;
	logic         inverse_ok;
	remote_idx_t  remote_idx;
	command_idx_t key_idx;

	always_comb
	begin
		remote_hit = 1'b0;
		remote_idx = '0;  // unknown remote reads back as remote 0
		for (int i = 0; i < 8; i++)
		begin
			if (!remote_hit && ir_code.addr == REMOTE_TABLE[i])
			begin
				remote_hit = 1'b1;
				remote_idx = remote_idx_t'(i);
			end
		end

		key_hit = 1'b0;
		key_idx = '0;
		for (int k = 0; k < 16; k++)
		begin
			if (!key_hit && ir_code.key[7:0] == KEY_TABLE[k])
			begin
				key_hit = 1'b1;
				key_idx = command_idx_t'(k);
			end
		end

		// upper key byte carries the complement as a check
		inverse_ok = (ir_code.key[15:8] == ~ir_code.key[7:0]);

		cap.invalid = !(remote_hit && key_hit && inverse_ok);
		cap.command = cap.invalid ? '0 : key_idx;
		cap.remote  = remote_idx;
	end

endmodule

`default_nettype wire

// File: src/ir_code_pkg.sv
`default_nettype none

package ir_code_pkg;

	// index of the remote that matched the address half
	typedef logic [2:0] remote_idx_t;

	// index of the key that matched the key half
	typedef logic [3:0] command_idx_t;

	// received word as the receiver front end hands it over
	typedef struct packed {
		logic [15:0] key;   // upper byte is the inverse of the lower byte
		logic [15:0] addr;  // remote address
	} ir_code_t;

	// low halfword of the result word, remote index at bit 0
	typedef struct packed {
		logic [12:0] zero;
		remote_idx_t remote;
	} remote_byte_t;

	// remote index shifted up by one for halfword access
	typedef struct packed {
		logic [11:0] zero;
		remote_idx_t remote;
		logic        lsb;
	} remote_half_t;

	// remote index shifted up by two for word access
	typedef struct packed {
		logic [10:0] zero;
		remote_idx_t remote;
		logic [1:0]  lsb;
	} remote_word_t;

	// one halfword, read in the layout chosen by the access select
	typedef union packed {
		remote_byte_t byte_f;
		remote_half_t half_f;
		remote_word_t word_f;
	} remote_field_u;

endpackage

`default_nettype wire

// File: src/ir_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ir_decoder import ir_code_pkg::*, bus_pkg::*; (
	input  logic        iCLK,
	input  logic        rst_n,
	// receiver front end
	input  ir_code_t    ir_code,
	input  logic        ir_ready,
	// processor bus
	input  access_sel_t sel,
	input  logic        read_en,
	input  bus_addr_t   read_addr,
	output bus_word_t   read_data
);

	capture_if cap_if ();  // decoded fields plus req/ack

	// table lookup, purely combinational
	ir_code_decode i_ir_code_decode (
		.ir_code (ir_code),
		.cap     (cap_if.decode_mp)
	);

	// settle window on the data-ready level
	ready_window i_ready_window (
		.iCLK     (iCLK),
		.rst_n    (rst_n),
		.ir_ready (ir_ready),
		.cap      (cap_if.window_mp)
	);

	// result register on the bus
	code_register i_code_register (
		.iCLK      (iCLK),
		.rst_n     (rst_n),
		.sel       (sel),
		.read_en   (read_en),
		.read_addr (read_addr),
		.read_data (read_data),
		.cap       (cap_if.register_mp)
	);

endmodule

`default_nettype wire

// File: src/ready_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "ir_decoder_params.svh"

module ready_window (
	input  logic          iCLK,
	input  logic          rst_n,
	input  logic          ir_ready,
	capture_if.window_mp  cap
);

	localparam int CNT_W = $clog2(`WINDOW_END + 1);

	logic [CNT_W-1:0] ready_cnt;  // cycles with data-ready held high
	logic             in_window;
	logic             req_q;

	assign in_window = (ready_cnt >= CNT_W'(`WINDOW_BEGIN)) &&
	                   (ready_cnt < CNT_W'(`WINDOW_END));

	always_ff @(posedge iCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ready_cnt <= '0;
			req_q     <= 1'b0;
		end
		else
		begin
			if (!ir_ready)
				ready_cnt <= '0;  // level dropped, start over
			else if (ready_cnt < CNT_W'(`WINDOW_END))
				ready_cnt <= ready_cnt + 1'b1;
			else
				ready_cnt <= '0;  // wrap, window may open again

			// a fresh request only once the last ack has returned low
			req_q <= ir_ready && in_window && (req_q || !cap.ack);
		end
	end

	assign cap.req = req_q;

endmodule

`default_nettype wire
